// File: rtl/wbuf_cfg_pkg.sv
package wbuf_cfg_pkg;

  ////////////////////////////////
  // buffer geometry
  ////////////////////////////////

  // number of coalescing entries, one 64 bit word each
  localparam int unsigned NUM_ENTRIES    = 8;
  // transaction slots shared by all entries
  localparam int unsigned NUM_TX         = 4;

  // word address is the byte address without the three offset bits
  localparam int unsigned WORD_ADDR_W    = 29;
  localparam int unsigned BYTES_PER_WORD = 8;
  localparam int unsigned DATA_W         = 8 * BYTES_PER_WORD;
  localparam int unsigned OFF_W          = $clog2(BYTES_PER_WORD);
  localparam int unsigned BYTE_ADDR_W    = WORD_ADDR_W + OFF_W;

  // derived index widths, at least one bit
  localparam int unsigned ENTRY_IDX_W    = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;
  localparam int unsigned TX_ID_W        = (NUM_TX > 1) ? $clog2(NUM_TX) : 1;

  typedef logic [ENTRY_IDX_W-1:0] entry_idx_t;
  typedef logic [TX_ID_W-1:0]     tx_id_t;

endpackage

// File: rtl/wbuf_xfer_pkg.sv
package wbuf_xfer_pkg;

  // memory side takes naturally aligned transfers only
  typedef enum logic [1:0] {
    XFER_BYTE   = 2'd0,
    XFER_HALF   = 2'd1,
    XFER_WORD   = 2'd2,
    XFER_DOUBLE = 2'd3
  } xfer_size_e;

  // offset of the lowest set byte, zero for an empty mask
  function automatic logic [2:0] xfer_low_off(input logic [7:0] mask);
    logic [2:0] off;
    off = '0;
    // scan downwards so the lowest set byte wins
    for (int i = 7; i >= 0; i--) begin
      if (mask[i]) begin
        off = 3'(i);
      end
    end
    return off;
  endfunction

  // largest aligned size starting at the lowest dirty byte,
  // e.g. 0011_1001 gives byte@0, then byte@3, then half@4
  function automatic xfer_size_e xfer_size_of(input logic [7:0] mask);
    logic [2:0] off;
    logic [7:0] run;
    xfer_size_e size;
    off = xfer_low_off(mask);
    // bytes from the start offset upwards
    run = mask >> off;
    if ((off == 3'd0) && (&run)) begin
      size = XFER_DOUBLE;
    end else if ((off[1:0] == 2'b00) && (&run[3:0])) begin
      size = XFER_WORD;
    end else if ((off[0] == 1'b0) && (&run[1:0])) begin
      size = XFER_HALF;
    end else begin
      size = XFER_BYTE;
    end
    return size;
  endfunction

  // byte enables covered by a transfer at off with the given size
  function automatic logic [7:0] xfer_be_of(input logic [2:0] off, input xfer_size_e size);
    logic [7:0] be;
    case (size)
      XFER_HALF:   be = 8'h03;
      XFER_WORD:   be = 8'h0f;
      XFER_DOUBLE: be = 8'hff;
      default:     be = 8'h01;
    endcase
    return be << off;
  endfunction

endpackage

// File: rtl/wbuf_alloc.sv
`timescale 1ns/1ps

module wbuf_alloc #(
  parameter int unsigned NumEntries = wbuf_cfg_pkg::NUM_ENTRIES
) (
  // core write request
  input  logic                                                 wr_req_i,
  input  logic [wbuf_cfg_pkg::WORD_ADDR_W-1:0]                 wr_addr_i,
  // entry state
  input  logic [NumEntries-1:0]                                entry_valid_i,
  input  logic [NumEntries-1:0][wbuf_cfg_pkg::WORD_ADDR_W-1:0] entry_tag_i,
  // grant back to the core, one-hot write select to the entries
  output logic                                                 wr_gnt_o,
  output logic [NumEntries-1:0]                                entry_wr_en_o
);

  logic [NumEntries-1:0] hit;
  logic [NumEntries-1:0] free_oh;
  logic                  any_hit;
  logic                  any_free;

  ////////////////////////////////
  // tag match
  ////////////////////////////////

  // a word lives in at most one entry, so hit is one-hot or zero
  always_comb begin : p_hit
    for (int k = 0; k < NumEntries; k++) begin
      hit[k] = entry_valid_i[k] && (entry_tag_i[k] == wr_addr_i);
    end
  end

  ////////////////////////////////
  // free entry search
  ////////////////////////////////

  // lowest entry without any valid byte
  always_comb begin : p_free
    logic found;
    found   = 1'b0;
    free_oh = '0;
    for (int k = 0; k < NumEntries; k++) begin
      if (!found && !entry_valid_i[k]) begin
        found      = 1'b1;
        free_oh[k] = 1'b1;
      end
    end
  end

  assign any_hit  = |hit;
  assign any_free = |free_oh;

  // merge into a hit, else allocate, else refuse
  assign wr_gnt_o = wr_req_i && (any_hit || any_free);

  // enable only the chosen entry and only on a grant
  always_comb begin : p_wr_en
    entry_wr_en_o = '0;
    if (wr_gnt_o) begin
      entry_wr_en_o = any_hit ? hit : free_oh;
    end
  end

endmodule

// File: rtl/wbuf_entry.sv
`timescale 1ns/1ps

module wbuf_entry (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // write from the allocator
  input  logic                                      wr_en_i,
  input  logic [wbuf_cfg_pkg::WORD_ADDR_W-1:0]      wr_tag_i,
  input  logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0]   wr_be_i,
  input  logic [wbuf_cfg_pkg::DATA_W-1:0]           wr_data_i,
  // transfer accepted by memory
  input  logic                                      send_en_i,
  input  logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0]   send_be_i,
  // transaction returned
  input  logic                                      rtrn_en_i,
  input  logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0]   rtrn_be_i,
  // entry state
  output logic                                      valid_o,
  output logic [wbuf_cfg_pkg::WORD_ADDR_W-1:0]      tag_o,
  output logic [wbuf_cfg_pkg::DATA_W-1:0]           data_o,
  output logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0]   ready_dirty_o
);

  import wbuf_cfg_pkg::*;

  // byte states valid/dirty/txblk
  //   000 free
  //   110 written, waiting to be sent
  //   101 in flight
  //   111 rewritten while in flight, resent after the return
  logic [BYTES_PER_WORD-1:0] valid_q;
  logic [BYTES_PER_WORD-1:0] dirty_q;
  logic [BYTES_PER_WORD-1:0] txblk_q;
  logic [WORD_ADDR_W-1:0]    tag_q;
  logic [DATA_W-1:0]         data_q;

  ////////////////////////////////
  // flag update
  ////////////////////////////////

  // return first, then send, then write
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_flags
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      txblk_q <= '0;
    end else begin
      valid_q <= ((valid_q & ~(rtrn_en_i ? (rtrn_be_i & ~dirty_q) : '0))
                 | (wr_en_i ? wr_be_i : '0));
      dirty_q <= ((dirty_q & ~(send_en_i ? send_be_i : '0))
                 | (wr_en_i ? wr_be_i : '0));
      txblk_q <= ((txblk_q & ~(rtrn_en_i ? rtrn_be_i : '0))
                 | (send_en_i ? send_be_i : '0));
    end
  end

  ////////////////////////////////
  // tag and data
  ////////////////////////////////

  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en_i) begin
      tag_q <= wr_tag_i;
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (wr_be_i[b]) begin
          data_q[b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  assign valid_o = |valid_q;
  assign tag_o   = tag_q;
  assign data_o  = data_q;

  // nothing is offered while any byte is in flight, since
  // transfers of one word must not overtake each other
  assign ready_dirty_o = (|txblk_q) ? '0 : (dirty_q & valid_q);

endmodule

// File: rtl/wbuf_dispatch.sv
`timescale 1ns/1ps

module wbuf_dispatch #(
  parameter int unsigned NumEntries = wbuf_cfg_pkg::NUM_ENTRIES,
  parameter int unsigned NumTx      = wbuf_cfg_pkg::NUM_TX
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  // entry side
  input  logic [NumEntries-1:0][wbuf_cfg_pkg::BYTES_PER_WORD-1:0] ready_dirty_i,
  input  logic [NumEntries-1:0][wbuf_cfg_pkg::WORD_ADDR_W-1:0]    entry_tag_i,
  input  logic [NumEntries-1:0][wbuf_cfg_pkg::DATA_W-1:0]         entry_data_i,
  // memory request
  output logic                                                    mem_req_o,
  input  logic                                                    mem_ack_i,
  output logic [wbuf_cfg_pkg::BYTE_ADDR_W-1:0]                    mem_addr_o,
  output wbuf_xfer_pkg::xfer_size_e                               mem_size_o,
  output logic [wbuf_cfg_pkg::DATA_W-1:0]                         mem_data_o,
  output wbuf_cfg_pkg::tx_id_t                                    mem_id_o,
  // memory return
  input  logic                                                    mem_rtrn_vld_i,
  input  wbuf_cfg_pkg::tx_id_t                                    mem_rtrn_id_i,
  // flag updates to the entries
  output logic [NumEntries-1:0]                                   send_en_o,
  output logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0]                 send_be_o,
  output logic [NumEntries-1:0]                                   rtrn_en_o,
  output logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0]                 rtrn_be_o
);

  import wbuf_cfg_pkg::*;
  import wbuf_xfer_pkg::*;

  // arbitration and lock
  entry_idx_t                rr_ptr_q;
  entry_idx_t                rr_pick;
  logic                      rr_found;
  logic                      lock_q;
  entry_idx_t                lock_ptr_q;
  logic [OFF_W-1:0]          lock_off_q;
  tx_id_t                    lock_id_q;

  // selected transfer
  entry_idx_t                sel_ptr;
  logic [OFF_W-1:0]          sel_off;
  logic [BYTES_PER_WORD-1:0] sel_mask;
  xfer_size_e                sel_size;
  logic [BYTES_PER_WORD-1:0] sel_be;
  logic                      have_work;
  logic                      take;

  // transaction slots
  logic [NumTx-1:0]                     slot_busy_q;
  entry_idx_t [NumTx-1:0]               slot_ptr_q;
  logic [NumTx-1:0][BYTES_PER_WORD-1:0] slot_be_q;
  tx_id_t                               free_id;
  logic                                 any_free;

  ////////////////////////////////
  // entry selection
  ////////////////////////////////

  // round robin, search starts after the entry served last
  always_comb begin : p_rr_pick
    int unsigned cand;
    rr_pick  = rr_ptr_q;
    rr_found = 1'b0;
    for (int unsigned i = 1; i <= NumEntries; i++) begin
      cand = (rr_ptr_q + i) % NumEntries;
      if (!rr_found && (|ready_dirty_i[cand])) begin
        rr_found = 1'b1;
        rr_pick  = entry_idx_t'(cand);
      end
    end
  end

  // a waiting request keeps its entry, offset and ID
  assign sel_ptr   = lock_q ? lock_ptr_q : rr_pick;
  assign have_work = lock_q || rr_found;
  assign sel_off   = lock_q ? lock_off_q : xfer_low_off(ready_dirty_i[sel_ptr]);

  // bytes below the start offset are left for a later transfer,
  // bytes written above it while waiting may grow the size
  assign sel_mask  = ready_dirty_i[sel_ptr] & ({BYTES_PER_WORD{1'b1}} << sel_off);
  assign sel_size  = xfer_size_of(sel_mask);
  assign sel_be    = xfer_be_of(sel_off, sel_size);

  ////////////////////////////////
  // slot allocation
  ////////////////////////////////

  // lowest free slot
  always_comb begin : p_free_slot
    free_id  = '0;
    any_free = 1'b0;
    for (int t = 0; t < NumTx; t++) begin
      if (!any_free && !slot_busy_q[t]) begin
        any_free = 1'b1;
        free_id  = tx_id_t'(t);
      end
    end
  end

  // a locked request already owns a free slot
  assign mem_req_o  = have_work && (lock_q || any_free);
  assign mem_id_o   = lock_q ? lock_id_q : free_id;
  assign mem_addr_o = {entry_tag_i[sel_ptr], sel_off};
  assign mem_size_o = sel_size;
  // data leaves in its natural byte lanes
  assign mem_data_o = entry_data_i[sel_ptr];
  assign take       = mem_req_o && mem_ack_i;

  ////////////////////////////////
  // entry updates
  ////////////////////////////////

  always_comb begin : p_enables
    for (int k = 0; k < NumEntries; k++) begin
      send_en_o[k] = take && (sel_ptr == entry_idx_t'(k));
      // return goes to the entry recorded in its slot
      rtrn_en_o[k] = mem_rtrn_vld_i && (slot_ptr_q[mem_rtrn_id_i] == entry_idx_t'(k));
    end
  end

  assign send_be_o = sel_be;
  assign rtrn_be_o = slot_be_q[mem_rtrn_id_i];

  ////////////////////////////////
  // registers
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      // entry 0 is searched first after reset
      rr_ptr_q    <= entry_idx_t'(NumEntries - 1);
      lock_q      <= 1'b0;
      lock_ptr_q  <= '0;
      lock_off_q  <= '0;
      lock_id_q   <= '0;
      slot_busy_q <= '0;
    end else begin
      if (take) begin
        lock_q   <= 1'b0;
        rr_ptr_q <= sel_ptr;
      end else if (mem_req_o && !lock_q) begin
        // memory stalls, hold the request as it is
        lock_q     <= 1'b1;
        lock_ptr_q <= sel_ptr;
        lock_off_q <= sel_off;
        lock_id_q  <= free_id;
      end
      // a returning ID is busy, a new one is free, never the same slot
      if (mem_rtrn_vld_i) begin
        slot_busy_q[mem_rtrn_id_i] <= 1'b0;
      end
      if (take) begin
        slot_busy_q[mem_id_o] <= 1'b1;
      end
    end
  end

  // slot payload, only meaningful while busy
  always_ff @(posedge clk_i) begin : p_slot_payload
    if (take) begin
      slot_ptr_q[mem_id_o] <= sel_ptr;
      slot_be_q[mem_id_o]  <= sel_be;
    end
  end

endmodule

// File: rtl/coalescing_wbuf.sv
`timescale 1ns/1ps

module coalescing_wbuf (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  // core writes
  input  logic                                    wr_req_i,
  input  logic [wbuf_cfg_pkg::WORD_ADDR_W-1:0]    wr_addr_i,
  input  logic [wbuf_cfg_pkg::BYTES_PER_WORD-1:0] wr_be_i,
  input  logic [wbuf_cfg_pkg::DATA_W-1:0]         wr_data_i,
  output logic                                    wr_gnt_o,
  // memory requests
  output logic                                    mem_req_o,
  input  logic                                    mem_ack_i,
  output logic [wbuf_cfg_pkg::BYTE_ADDR_W-1:0]    mem_addr_o,
  output wbuf_xfer_pkg::xfer_size_e               mem_size_o,
  output logic [wbuf_cfg_pkg::DATA_W-1:0]         mem_data_o,
  output wbuf_cfg_pkg::tx_id_t                    mem_id_o,
  // memory returns
  input  logic                                    mem_rtrn_vld_i,
  input  wbuf_cfg_pkg::tx_id_t                    mem_rtrn_id_i,
  // no valid byte left anywhere
  output logic                                    empty_o
);

  import wbuf_cfg_pkg::*;

  localparam int unsigned NumEntries = NUM_ENTRIES;
  localparam int unsigned NumTx      = NUM_TX;

  logic [NumEntries-1:0]                     entry_valid;
  logic [NumEntries-1:0][WORD_ADDR_W-1:0]    entry_tag;
  logic [NumEntries-1:0][DATA_W-1:0]         entry_data;
  logic [NumEntries-1:0][BYTES_PER_WORD-1:0] ready_dirty;
  logic [NumEntries-1:0]                     entry_wr_en;
  logic [NumEntries-1:0]                     send_en;
  logic [NumEntries-1:0]                     rtrn_en;
  logic [BYTES_PER_WORD-1:0]                 send_be;
  logic [BYTES_PER_WORD-1:0]                 rtrn_be;

  // hit or lowest free entry
  wbuf_alloc #(
    .NumEntries ( NumEntries )
  ) i_alloc (
    .wr_req_i      ( wr_req_i    ),
    .wr_addr_i     ( wr_addr_i   ),
    .entry_valid_i ( entry_valid ),
    .entry_tag_i   ( entry_tag   ),
    .wr_gnt_o      ( wr_gnt_o    ),
    .entry_wr_en_o ( entry_wr_en )
  );

  for (genvar k = 0; k < NumEntries; k++) begin : gen_entries
    wbuf_entry i_entry (
      .clk_i         ( clk_i          ),
      .rst_ni        ( rst_ni         ),
      .wr_en_i       ( entry_wr_en[k] ),
      .wr_tag_i      ( wr_addr_i      ),
      .wr_be_i       ( wr_be_i        ),
      .wr_data_i     ( wr_data_i      ),
      .send_en_i     ( send_en[k]     ),
      .send_be_i     ( send_be        ),
      .rtrn_en_i     ( rtrn_en[k]     ),
      .rtrn_be_i     ( rtrn_be        ),
      .valid_o       ( entry_valid[k] ),
      .tag_o         ( entry_tag[k]   ),
      .data_o        ( entry_data[k]  ),
      .ready_dirty_o ( ready_dirty[k] )
    );
  end

  // aligned transfers and transaction slots
  wbuf_dispatch #(
    .NumEntries ( NumEntries ),
    .NumTx      ( NumTx      )
  ) i_dispatch (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ready_dirty_i  ( ready_dirty    ),
    .entry_tag_i    ( entry_tag      ),
    .entry_data_i   ( entry_data     ),
    .mem_req_o      ( mem_req_o      ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_size_o     ( mem_size_o     ),
    .mem_data_o     ( mem_data_o     ),
    .mem_id_o       ( mem_id_o       ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_id_i  ( mem_rtrn_id_i  ),
    .send_en_o      ( send_en        ),
    .send_be_o      ( send_be        ),
    .rtrn_en_o      ( rtrn_en        ),
    .rtrn_be_o      ( rtrn_be        )
  );

  assign empty_o = ~(|entry_valid);

endmodule

// File: verif/tb_coalescing_wbuf.sv
`timescale 1ns/1ps

module tb_coalescing_wbuf;

  import wbuf_cfg_pkg::*;
  import wbuf_xfer_pkg::*;

  // one row of the stimulus table
  typedef struct {
    logic [WORD_ADDR_W-1:0] addr;
    logic [7:0]             be;
    logic [DATA_W-1:0]      data;
    bit                     hold;    // memory holds ack from this write on
    bit                     refuse;  // first attempt must be refused
    int                     after;   // transfers seen before the write starts
    int                     xfers;   // transfers expected at the drain, -1 no drain
  } row_t;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   wr_req_i;
  logic [WORD_ADDR_W-1:0] wr_addr_i;
  logic [7:0]             wr_be_i;
  logic [DATA_W-1:0]      wr_data_i;
  logic                   wr_gnt_o;
  logic                   mem_req_o;
  logic                   mem_ack_i;
  logic [BYTE_ADDR_W-1:0] mem_addr_o;
  xfer_size_e             mem_size_o;
  logic [DATA_W-1:0]      mem_data_o;
  tx_id_t                 mem_id_o;
  logic                   mem_rtrn_vld_i;
  tx_id_t                 mem_rtrn_id_i;
  logic                   empty_o;

  row_t             rows[$];
  logic [7:0]       exp_img [bit [31:0]];
  logic [7:0]       mem_img [bit [31:0]];
  logic [NUM_TX-1:0] busy = '0;
  int               dly [NUM_TX];
  int               xfer_cnt = 0;
  int               errors = 0;
  int               cycles = 0;
  int               limit = 0;
  bit               hold_ack = 1'b0;

  coalescing_wbuf dut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .wr_req_i       ( wr_req_i       ),
    .wr_addr_i      ( wr_addr_i      ),
    .wr_be_i        ( wr_be_i        ),
    .wr_data_i      ( wr_data_i      ),
    .wr_gnt_o       ( wr_gnt_o       ),
    .mem_req_o      ( mem_req_o      ),
    .mem_ack_i      ( mem_ack_i      ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_size_o     ( mem_size_o     ),
    .mem_data_o     ( mem_data_o     ),
    .mem_id_o       ( mem_id_o       ),
    .mem_rtrn_vld_i ( mem_rtrn_vld_i ),
    .mem_rtrn_id_i  ( mem_rtrn_id_i  ),
    .empty_o        ( empty_o        )
  );

  always #4 clk_i = ~clk_i;

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("FAIL @%0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  task automatic add_row(input logic [WORD_ADDR_W-1:0] addr, input logic [7:0] be,
                         input logic [DATA_W-1:0] data, input bit hold, input bit refuse,
                         input int after, input int xfers);
    row_t r;
    r = '{addr, be, data, hold, refuse, after, xfers};
    rows.push_back(r);
  endtask

  //////////////////////////////
  // memory model
  //////////////////////////////

  // sampled at the falling edge, req and ack are stable there
  always @(negedge clk_i) begin : p_accept
    int n;
    if (rst_ni && mem_req_o && mem_ack_i) begin
      n = 1 << int'(mem_size_o);
      check_eq(64'(mem_addr_o % n), 64'd0, "transfer not naturally aligned");
      check_eq(64'(busy[mem_id_o]), 64'd0, "ID reused while outstanding");
      // bytes sit in their natural lanes
      for (int b = 0; b < n; b++) begin
        mem_img[mem_addr_o + 32'(b)] = mem_data_o[(int'(mem_addr_o[2:0]) + b) * 8 +: 8];
      end
      busy[mem_id_o] = 1'b1;
      dly[mem_id_o]  = int'($urandom_range(1, 6));
      xfer_cnt++;
    end
  end

  // returns and ack, driven just after the rising edge
  always @(posedge clk_i) begin : p_respond
    bit hold_now;
    bit found;
    hold_now = hold_ack;
    #1;
    // the return strobed last cycle has been taken
    if (mem_rtrn_vld_i) begin
      busy[mem_rtrn_id_i] = 1'b0;
    end
    mem_rtrn_vld_i = 1'b0;
    found = 1'b0;
    for (int t = 0; t < NUM_TX; t++) begin
      if (busy[t] && dly[t] > 0) begin
        dly[t]--;
      end
      // one return per cycle, the others wait
      if (busy[t] && dly[t] == 0 && !found) begin
        found          = 1'b1;
        mem_rtrn_vld_i = 1'b1;
        mem_rtrn_id_i  = tx_id_t'(t);
      end
    end
    // random stalls, none while ack is held
    mem_ack_i = !hold_now && ($urandom_range(0, 3) != 0);
  end

  always @(posedge clk_i) begin : p_timeout
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("errors: %0d, run stopped by timeout after %0d cycles", errors, cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////
  // table driver
  //////////////////////////////

  // wait until nothing is buffered or outstanding
  task automatic drain_and_check(input int xfers);
    do @(negedge clk_i); while (!(empty_o && busy == '0));
    check_eq(64'(xfer_cnt), 64'(xfers), "transfer count");
    check_eq(64'(mem_img.num()), 64'(exp_img.num()), "image size");
    foreach (exp_img[a]) begin
      check_eq(64'(mem_img.exists(a)), 64'd1, $sformatf("byte %0h never written", a));
      check_eq(64'(mem_img[a]), 64'(exp_img[a]), $sformatf("image byte %0h", a));
    end
    xfer_cnt = 0;
  endtask

  task automatic apply_row(input row_t r);
    bit granted;
    bit refused;
    granted = 1'b0;
    refused = 1'b0;
    @(posedge clk_i);
    while (xfer_cnt < r.after) @(posedge clk_i);
    #1;
    hold_ack  = r.hold;
    wr_req_i  = 1'b1;
    wr_addr_i = r.addr;
    wr_be_i   = r.be;
    wr_data_i = r.data;
    // held until granted
    forever begin
      @(negedge clk_i);
      granted = wr_gnt_o;
      if (!granted) begin
        refused = 1'b1;
      end
      @(posedge clk_i);
      if (granted) break;
    end
    // last write wins per byte
    for (int b = 0; b < 8; b++) begin
      if (r.be[b]) begin
        exp_img[{r.addr, 3'b000} + 32'(b)] = r.data[b*8 +: 8];
      end
    end
    #1;
    wr_req_i = 1'b0;
    check_eq(64'(refused), 64'(r.refuse), $sformatf("first attempt refused, word %0h", r.addr));
    if (r.xfers >= 0) begin
      drain_and_check(r.xfers);
    end
  endtask

  initial begin : p_main
    void'($urandom(32'h300303ac));
    rst_ni         = 1'b0;
    wr_req_i       = 1'b0;
    wr_addr_i      = '0;
    wr_be_i        = '0;
    wr_data_i      = '0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_id_i  = '0;
    // full word, one double
    add_row(29'h100, 8'hff, 64'h0011223344556677, 0, 0, 0, 1);
    // two halves under held ack merge into one double
    add_row(29'h101, 8'h0f, 64'h00000000a1a2a3a4, 1, 0, 0, -1);
    add_row(29'h101, 8'hf0, 64'hb5b6b7b800000000, 0, 0, 0, 1);
    // byte@0, byte@3, half@4
    add_row(29'h102, 8'h39, 64'h0000c5c4c3c2c1c0, 0, 0, 0, 3);
    // fill every entry under held ack, the ninth word must wait
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      add_row(29'h200 + 29'(k), 8'hff, {8{8'(8'h10 + k)}}, 1, 0, 0, -1);
    end
    add_row(29'h208, 8'hff, 64'hfedcba9876543210, 0, 1, 0, NUM_ENTRIES + 1);
    // rewrite once the first transfer is taken
    add_row(29'h300, 8'hff, 64'ha7a6a5a4a3a2a1a0, 0, 0, 0, -1);
    add_row(29'h300, 8'h0f, 64'h00000000d3d2d1d0, 0, 0, 1, 2);
    limit = rows.size() * 40 + 200;

    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_eq(64'(wr_gnt_o), 64'd0, "grant during reset");
    check_eq(64'(mem_req_o), 64'd0, "request during reset");
    check_eq(64'(empty_o), 64'd1, "empty during reset");
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    // a drained buffer stays empty and quiet
    repeat (4) @(negedge clk_i);
    check_eq(64'(empty_o), 64'd1, "empty at the end");
    check_eq(64'(mem_req_o), 64'd0, "request after the drain");
    check_eq(64'(xfer_cnt), 64'd0, "transfer after the drain");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/wbuf_cfg_pkg.sv
rtl/wbuf_xfer_pkg.sv
rtl/wbuf_alloc.sv
rtl/wbuf_entry.sv
rtl/wbuf_dispatch.sv
rtl/coalescing_wbuf.sv
verif/tb_coalescing_wbuf.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f \
  --top-module tb_coalescing_wbuf -o tb_coalescing_wbuf \
  && ./obj_dir/tb_coalescing_wbuf | tee /dev/stderr | grep -q "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
